//--- dv/lc4_testdata.txt
# P addr insn | R pc insn rd_we rd wdata stall | M addr data
# all fields hex; stall 0 normal, 2 branch squash, 3 load-to-use bubble
# program at the reset pc
P 0100 9205
P 0101 9403
P 0102 1642
P 0103 18D1
P 0104 1B3E
P 0105 9E40
P 0106 7BC0
P 0107 63C0
P 0108 1441
P 0109 75C1
P 010A 18BE
P 010B 0402
P 010C 9A63
P 010D 9C4D
P 010E 9BFF
P 010F 0603
P 0110 1D45
P 0111 7DC2
# expected retire order
R 0100 9205 1 1 0005 0
R 0101 9403 1 2 0003 0
R 0102 1642 1 3 0008 0
R 0103 18D1 1 4 0003 0
R 0104 1B3E 1 5 0001 0
R 0105 9E40 1 7 0040 0
R 0106 7BC0 0 0 0000 0
R 0107 63C0 1 1 0001 0
R 0000 0000 0 0 0000 3
R 0108 1441 1 2 0002 0
R 0109 75C1 0 0 0000 0
R 010A 18BE 1 4 0000 0
R 010B 0402 0 0 0000 0
R 0000 0000 0 0 0000 2
R 0000 0000 0 0 0000 2
R 010E 9BFF 1 5 FFFF 0
R 010F 0603 0 0 0000 0
R 0110 1D45 1 6 FFFE 0
R 0111 7DC2 0 0 0000 0
# final data memory
M 0040 0001
M 0041 0002
M 0042 FFFE
M 0043 0000

//--- lc4_pipeline.f
design/lc4_pkg.sv
design/lc4_decoder.sv
design/lc4_alu.sv
design/lc4_regfile.sv
design/lc4_hazard_unit.sv
design/lc4_pipeline.sv
dv/lc4_pipeline_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps --top-module lc4_pipeline_tb \
    -f lc4_pipeline.f -o lc4_sim \
    && ./obj_dir/lc4_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"

//--- dv/lc4_pipeline_tb.sv
module lc4_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import lc4_pkg::*;

    localparam word_t PROG_BASE = 16'h0100;
    localparam string DATA_FILE = "dv/lc4_testdata.txt";

    logic   gwe;
    logic   rst_n;
    word_t  cur_pc;
    word_t  cur_insn;
    word_t  dmem_addr;
    word_t  dmem_rdata;
    word_t  dmem_wdata;
    logic   dmem_we;
    trace_t wb_trace;

    // unlisted addresses read as 0 and decode as a never-taken branch
    word_t  imem [65536] = '{default: '0};
    word_t  dmem [65536] = '{default: '0};

    trace_t exp_retire [$];
    word_t  exp_mem_addr [$];
    word_t  exp_mem_data [$];
    int     errors;
    int     checks;
    int     rline;
    int     cycles;
    int     limit;
    logic   started;

    lc4_pipeline #(
        .RESET_PC (PROG_BASE)
    ) dut_i (
        .gwe          (gwe),
        .i_rst_n      (rst_n),
        .o_cur_pc     (cur_pc),
        .i_cur_insn   (cur_insn),
        .o_dmem_addr  (dmem_addr),
        .i_dmem_rdata (dmem_rdata),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .o_trace      (wb_trace)
    );

    always #10 gwe = ~gwe;

    // both memories answer in the same cycle
    assign cur_insn   = imem[cur_pc];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_testdata();
        int     fd;
        int     n;
        int     ch;
        byte    tag;
        word_t  v0, v1, v2, v3, v4, v5;
        trace_t exp;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("error: cannot open %s", DATA_FILE);
            errors++;
            return;
        end
        forever begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                break;
            end
            case (tag)
                "P": begin
                    n = $fscanf(fd, "%h %h", v0, v1);
                    imem[v0] = v1;
                end
                "R": begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
                    if (n != 6) begin
                        $display("error: short retire line in %s", DATA_FILE);
                        errors++;
                    end
                    exp       = '0;
                    exp.pc    = v0;
                    exp.insn  = v1;
                    exp.rd_we = v2[0];
                    exp.rd    = v3[2:0];
                    exp.wdata = v4;
                    exp.stall = v5[1:0];
                    exp_retire.push_back(exp);
                end
                "M": begin
                    n = $fscanf(fd, "%h %h", v0, v1);
                    exp_mem_addr.push_back(v0);
                    exp_mem_data.push_back(v1);
                end
                default: begin
                    if (tag != "#") begin
                        $display("error: unknown line tag %c in %s", tag, DATA_FILE);
                        errors++;
                    end
                    // drop the rest of the line
                    ch = 0;
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic check_retire(input trace_t exp);
        string name;
        logic  exp_store;
        nzp_t  exp_nzp;
        name      = $sformatf("retire %0d at pc %h", rline, exp.pc);
        exp_store = (exp.insn[15:12] == OP_STR);
        // n z p of the written value
        if (exp.wdata[15]) begin
            exp_nzp = 3'b100;
        end else if (exp.wdata == 16'd0) begin
            exp_nzp = 3'b010;
        end else begin
            exp_nzp = 3'b001;
        end
        compare_word({name, " pc"}, exp.pc, wb_trace.pc);
        compare_word({name, " insn"}, exp.insn, wb_trace.insn);
        compare_word({name, " rd_we"}, {15'd0, exp.rd_we}, {15'd0, wb_trace.rd_we});
        compare_word({name, " stall"}, {14'd0, exp.stall}, {14'd0, wb_trace.stall});
        // every register writer of this instruction set also sets nzp
        compare_word({name, " nzp_we"}, {15'd0, exp.rd_we}, {15'd0, wb_trace.nzp_we});
        compare_word({name, " dmem_we"}, {15'd0, exp_store}, {15'd0, wb_trace.dmem_we});
        // rd and wdata only carry meaning for a register write
        if (exp.rd_we) begin
            compare_word({name, " rd"}, {13'd0, exp.rd}, {13'd0, wb_trace.rd});
            compare_word({name, " wdata"}, exp.wdata, wb_trace.wdata);
            compare_word({name, " nzp"}, {13'd0, exp_nzp}, {13'd0, wb_trace.nzp});
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < exp_mem_addr.size(); i++) begin
            compare_word($sformatf("final dmem[%h]", exp_mem_addr[i]),
                         exp_mem_data[i], dmem[exp_mem_addr[i]]);
        end
    endtask

    initial begin
        gwe     = 1'b0;
        rst_n   = 1'b0;
        errors  = 0;
        checks  = 0;
        rline   = 0;
        cycles  = 0;
        started = 1'b0;
        load_testdata();
        if (exp_retire.size() == 0) begin
            $display("error: no expected retirements in %s", DATA_FILE);
            errors++;
        end
        repeat (2) @(posedge gwe);
        #1 rst_n = 1'b1;
        @(negedge gwe);
        compare_word("reset pc", PROG_BASE, cur_pc);
        compare_word("reset dmem_we", 16'd0, {15'd0, dmem_we});
        limit = exp_retire.size() + 30;
        while (rline < exp_retire.size() && cycles < limit) begin
            // reset bubbles leave writeback with the branch stall code
            if (wb_trace.stall != STALL_BRANCH) begin
                started = 1'b1;
            end
            if (started) begin
                check_retire(exp_retire[rline]);
                rline++;
            end
            cycles++;
            @(negedge gwe);
        end
        if (rline < exp_retire.size()) begin
            $display("error: timeout after %0d cycles, %0d of %0d retirements seen",
                     cycles, rline, exp_retire.size());
            errors++;
        end else begin
            check_memory();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- design/lc4_pipeline.sv
module lc4_pipeline #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic             gwe,
    input  logic             i_rst_n,
    output lc4_pkg::word_t   o_cur_pc,
    input  lc4_pkg::word_t   i_cur_insn,
    output lc4_pkg::word_t   o_dmem_addr,
    input  lc4_pkg::word_t   i_dmem_rdata,
    output logic             o_dmem_we,
    output lc4_pkg::word_t   o_dmem_wdata,
    output lc4_pkg::trace_t  o_trace
);
    import lc4_pkg::*;

    function automatic nzp_t nzp_of(input word_t value);
        return value[15] ? NZP_N : ((value == '0) ? NZP_Z : NZP_P);
    endfunction

    word_t    pc;
    nzp_t     nzp_reg;
    logic     stall_d, squash, st_sel_m;
    byp_sel_t rs_sel_x, rt_sel_x;

    // decode
    word_t    d_insn, d_pc, d_rs_data, d_rt_data;
    stall_t   d_stall;
    ctrl_t    d_dec_ctrl, d_ctrl;
    // execute
    ctrl_t    x_ctrl;
    word_t    x_pc, x_rs, x_rt, x_rs_fwd, x_rt_fwd, x_result;
    stall_t   x_stall;
    nzp_t     x_nzp;
    logic     x_taken, x_nzp_we;
    // memory
    ctrl_t    m_ctrl;
    word_t    m_pc, m_result, m_st_data, m_st_fwd;
    stall_t   m_stall;
    nzp_t     m_nzp;
    logic     m_mem;
    // writeback
    ctrl_t    w_ctrl;
    word_t    w_pc, w_result, w_mdata, w_wdata;
    stall_t   w_stall;
    nzp_t     w_nzp;
    logic     w_mem;

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctrl (d_dec_ctrl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (d_dec_ctrl.rs),
        .i_rt      (d_dec_ctrl.rt),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data),
        .i_rd      (w_ctrl.rd),
        .i_wdata   (w_wdata),
        .i_we      (w_ctrl.rd_we)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl   (d_ctrl),
        .i_x_ctrl   (x_ctrl),
        .i_m_ctrl   (m_ctrl),
        .i_w_ctrl   (w_ctrl),
        .i_x_taken  (x_taken),
        .o_stall_d  (stall_d),
        .o_squash   (squash),
        .o_rs_sel_x (rs_sel_x),
        .o_rt_sel_x (rt_sel_x),
        .o_st_sel_m (st_sel_m)
    );

    lc4_alu u_alu (
        .i_insn    (x_ctrl.insn),
        .i_pc      (x_pc),
        .i_rs_data (x_rs_fwd),
        .i_rt_data (x_rt_fwd),
        .o_result  (x_result)
    );

    // a squashed or reset slot in decode carries no work
    assign d_ctrl = (d_stall == STALL_NONE) ? d_dec_ctrl : '0;

    assign x_rs_fwd = (rs_sel_x == BYP_M) ? m_result :
                      (rs_sel_x == BYP_W) ? w_wdata : x_rs;
    assign x_rt_fwd = (rt_sel_x == BYP_M) ? m_result :
                      (rt_sel_x == BYP_W) ? w_wdata : x_rt;
    assign x_nzp    = nzp_of(x_result);
    assign x_taken  = x_ctrl.is_branch && ((nzp_reg & x_ctrl.insn[11:9]) != '0);
    // a load sets nzp from memory one stage later
    assign x_nzp_we = x_ctrl.nzp_we && !x_ctrl.is_load;

    assign m_mem        = m_ctrl.is_load || m_ctrl.is_store;
    assign m_st_fwd     = st_sel_m ? w_wdata : m_st_data;
    assign o_dmem_addr  = m_mem ? m_result : '0;
    assign o_dmem_we    = m_ctrl.is_store;
    assign o_dmem_wdata = m_st_fwd;

    assign w_mem   = w_ctrl.is_load || w_ctrl.is_store;
    assign w_wdata = w_ctrl.is_load ? w_mdata : w_result;

    assign o_cur_pc = pc;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc      <= RESET_PC;
            nzp_reg <= '0;
            d_insn  <= '0;
            d_pc    <= '0;
            d_stall <= STALL_BRANCH;
            x_ctrl  <= '0;
            x_pc    <= '0;
            x_stall <= STALL_BRANCH;
            m_ctrl  <= '0;
            m_pc    <= '0;
            m_stall <= STALL_BRANCH;
            w_ctrl  <= '0;
            w_pc    <= '0;
            w_stall <= STALL_BRANCH;
        end else begin
            if (squash) begin
                pc <= x_result;
            end else if (!stall_d) begin
                pc <= pc + 16'd1;
            end
            // fetch into decode
            if (squash) begin
                d_insn  <= '0;
                d_pc    <= '0;
                d_stall <= STALL_BRANCH;
            end else if (!stall_d) begin
                d_insn  <= i_cur_insn;
                d_pc    <= pc;
                d_stall <= STALL_NONE;
            end
            // execute takes a bubble on squash or load-to-use
            if (squash || stall_d) begin
                x_ctrl  <= '0;
                x_pc    <= '0;
                x_stall <= squash ? STALL_BRANCH : STALL_LOAD;
            end else begin
                x_ctrl  <= d_ctrl;
                x_pc    <= d_pc;
                x_stall <= d_stall;
            end
            m_ctrl  <= x_ctrl;
            m_pc    <= x_pc;
            m_stall <= x_stall;
            w_ctrl  <= m_ctrl;
            w_pc    <= m_pc;
            w_stall <= m_stall;
            // execute is younger than memory, so its write wins
            if (x_nzp_we) begin
                nzp_reg <= x_nzp;
            end else if (m_ctrl.is_load) begin
                nzp_reg <= nzp_of(i_dmem_rdata);
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs      <= d_rs_data;
        x_rt      <= d_rt_data;
        m_result  <= x_result;
        m_st_data <= x_rt_fwd;
        m_nzp     <= x_nzp;
        w_result  <= m_result;
        // loaded word for loads, final store data otherwise
        w_mdata   <= m_ctrl.is_load ? i_dmem_rdata : m_st_fwd;
        w_nzp     <= m_ctrl.is_load ? nzp_of(i_dmem_rdata) : m_nzp;
    end

    always_comb begin
        o_trace           = '0;
        o_trace.pc        = w_pc;
        o_trace.insn      = w_ctrl.insn;
        o_trace.rd_we     = w_ctrl.rd_we;
        o_trace.rd        = w_ctrl.rd;
        o_trace.wdata     = w_wdata;
        o_trace.nzp_we    = w_ctrl.nzp_we;
        o_trace.nzp       = w_nzp;
        o_trace.dmem_we   = w_ctrl.is_store;
        o_trace.dmem_addr = w_mem ? w_result : '0;
        o_trace.dmem_data = w_mem ? w_mdata : '0;
        o_trace.stall     = w_stall;
    end

endmodule

//--- design/lc4_hazard_unit.sv
module lc4_hazard_unit (
    input  lc4_pkg::ctrl_t    i_d_ctrl,
    input  lc4_pkg::ctrl_t    i_x_ctrl,
    input  lc4_pkg::ctrl_t    i_m_ctrl,
    input  lc4_pkg::ctrl_t    i_w_ctrl,
    input  logic              i_x_taken,
    output logic              o_stall_d,
    output logic              o_squash,
    output lc4_pkg::byp_sel_t o_rs_sel_x,
    output lc4_pkg::byp_sel_t o_rt_sel_x,
    output logic              o_st_sel_m
);
    import lc4_pkg::*;

    logic load_use;

    // youngest producer wins; a load in M only has its address so far
    function automatic byp_sel_t pick_source(input logic re, input reg_idx_t idx,
                                             input ctrl_t m_ctrl, input ctrl_t w_ctrl);
        byp_sel_t sel;
        sel = BYP_NONE;
        if (re && m_ctrl.rd_we && !m_ctrl.is_load && m_ctrl.rd == idx) begin
            sel = BYP_M;
        end else if (re && w_ctrl.rd_we && w_ctrl.rd == idx) begin
            sel = BYP_W;
        end
        return sel;
    endfunction

    assign o_rs_sel_x = pick_source(i_x_ctrl.rs_re, i_x_ctrl.rs, i_m_ctrl, i_w_ctrl);
    assign o_rt_sel_x = pick_source(i_x_ctrl.rt_re, i_x_ctrl.rt, i_m_ctrl, i_w_ctrl);

    // store data catches a load result one stage late, in M
    assign o_st_sel_m = i_m_ctrl.is_store && i_w_ctrl.rd_we &&
                        (i_w_ctrl.rd == i_m_ctrl.rt);

    // load in X against decode; a branch waits for the load's nzp
    assign load_use = i_x_ctrl.is_load && i_x_ctrl.rd_we && (
                          (i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd) ||
                          (i_d_ctrl.rt_re && !i_d_ctrl.is_store &&
                           i_d_ctrl.rt == i_x_ctrl.rd) ||
                          i_d_ctrl.is_branch);

    // the squash throws decode away, so it takes priority
    assign o_squash  = i_x_taken;
    assign o_stall_d = load_use && !i_x_taken;

endmodule

//--- design/lc4_regfile.sv
module lc4_regfile (
    input  logic               gwe,
    input  logic               i_rst_n,
    input  lc4_pkg::reg_idx_t  i_rs,
    input  lc4_pkg::reg_idx_t  i_rt,
    output lc4_pkg::word_t     o_rs_data,
    output lc4_pkg::word_t     o_rt_data,
    input  lc4_pkg::reg_idx_t  i_rd,
    input  lc4_pkg::word_t     i_wdata,
    input  logic               i_we
);
    import lc4_pkg::*;

    word_t regs [8];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // a write in this cycle is visible to decode right away
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

//--- design/lc4_alu.sv
module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_rs_data,
    input  lc4_pkg::word_t i_rt_data,
    output lc4_pkg::word_t o_result
);
    import lc4_pkg::*;

    word_t imm5;
    word_t imm6;
    word_t imm9;

    // sign-extended immediates
    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_insn[15:12])
            OP_BR:    o_result = i_pc + 16'd1 + imm9;
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else if (i_insn[4]) begin
                    o_result = i_rs_data - i_rt_data;
                end else begin
                    o_result = i_rs_data + i_rt_data;
                end
            end
            // effective address for loads and stores
            OP_LDR,
            OP_STR:   o_result = i_rs_data + imm6;
            OP_CONST: o_result = imm9;
            default:  o_result = '0;
        endcase
    end

endmodule

//--- design/lc4_decoder.sv
module lc4_decoder (
    input  lc4_pkg::word_t i_insn,
    output lc4_pkg::ctrl_t o_ctrl
);
    import lc4_pkg::*;

    opcode_t opcode;

    assign opcode = i_insn[15:12];

    always_comb begin
        o_ctrl      = '0;
        o_ctrl.insn = i_insn;
        case (opcode)
            OP_BR: begin
                // needs only the nzp register, no gprs
                o_ctrl.is_branch = 1'b1;
            end
            OP_ARITH: begin
                // add, sub and add-immediate; mul and div stay no-ops
                if (i_insn[5] || !i_insn[3]) begin
                    o_ctrl.rd     = i_insn[11:9];
                    o_ctrl.rs     = i_insn[8:6];
                    o_ctrl.rt     = i_insn[2:0];
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = !i_insn[5];
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.rd      = i_insn[11:9];
                o_ctrl.rs      = i_insn[8:6];
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                // store data comes from the rd field position
                o_ctrl.rt       = i_insn[11:9];
                o_ctrl.rs       = i_insn[8:6];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.rd     = i_insn[11:9];
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- design/lc4_pkg.sv
package lc4_pkg;

    // data, address and instruction words
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    // one-hot condition code, n z p from msb to lsb
    typedef logic [2:0]  nzp_t;
    typedef logic [1:0]  stall_t;
    typedef logic [3:0]  opcode_t;
    // bypass source for an execute operand
    typedef logic [1:0]  byp_sel_t;

    localparam stall_t STALL_NONE   = 2'd0;
    localparam stall_t STALL_BRANCH = 2'd2;
    localparam stall_t STALL_LOAD   = 2'd3;

    localparam opcode_t OP_BR    = 4'b0000;
    localparam opcode_t OP_ARITH = 4'b0001;
    localparam opcode_t OP_LDR   = 4'b0110;
    localparam opcode_t OP_STR   = 4'b0111;
    localparam opcode_t OP_CONST = 4'b1001;

    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    localparam byp_sel_t BYP_NONE = 2'd0;
    localparam byp_sel_t BYP_M    = 2'd1;
    localparam byp_sel_t BYP_W    = 2'd2;

    // decoded control, all zero is a bubble
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        word_t    insn;
    } ctrl_t;

    // what the instruction in writeback did this cycle
    typedef struct packed {
        word_t    pc;
        word_t    insn;
        logic     rd_we;
        reg_idx_t rd;
        word_t    wdata;
        logic     nzp_we;
        nzp_t     nzp;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
        stall_t   stall;
    } trace_t;

endpackage
